/* logic/cft_flag_pkg.sv */
// Shared flag constants; the byte layout assumes bus bits 15..8 map to byte bits 7..0
package cft_flag_pkg;

   ////////////////////////////////////////////////////////////
   // Flag byte layout
   ////////////////////////////////////////////////////////////

   // Bit positions within the flag byte, same on IBUS[15:8] and the front panel
   // Bit 6 is reserved and reads zero, bits 1 and 0 are unused
   localparam int FLAG_BIT_FI = 7;
   localparam int FLAG_BIT_FV = 5;
   localparam int FLAG_BIT_FL = 4;
   localparam int FLAG_BIT_FZ = 3;
   localparam int FLAG_BIT_FN = 2;

   ////////////////////////////////////////////////////////////
   // Register file addresses
   ////////////////////////////////////////////////////////////

   // Both addresses sit in the 01xxx block of the register map
   // Address 13 used to select the MBP copy, here it aliases the flags
   localparam logic [4:0] ADDR_MBP_FLAGS = 5'd13;
   localparam logic [4:0] ADDR_FLAGS     = 5'd14;

   ////////////////////////////////////////////////////////////
   // ALU operations
   ////////////////////////////////////////////////////////////

   // Arithmetic ops touch all four ALU flags
   // Logic ops touch only N and Z
   // CPL and CLL act on the link and pass operand a through
   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      NOT = 3'd5,
      CPL = 3'd6,
      CLL = 3'd7
   } alu_op_t;

endpackage

/* logic/flag_bus_if.sv */
// Flag values plus update strobes; strobes are single-cycle levels with no handshake
interface flag_bus_if;

   // Flag values, all active high
   logic fn;
   logic fz;
   logic fl;
   logic fv;
   logic fi;

   // Update strobes, sampled at the clk4 edge
   logic upd_nz;
   logic upd_lv;

   // Producer side drives everything
   modport src (
      output fn, fz, fl, fv, fi,
      output upd_nz, upd_lv
   );

   // Register side takes values and strobes
   modport sink (
      input fn, fz, fl, fv, fi,
      input upd_nz, upd_lv
   );

   // Read-only view of the settled flags
   modport view (
      input fn, fz, fl, fv, fi
   );

endinterface

/* logic/alu_flags.sv */
// Pure combinational ALU; flag strobes are only valid while alu_strobe is high
module alu_flags #(
   parameter int DATA_WIDTH = 16
) (
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   input  cft_flag_pkg::alu_op_t op,
   input  logic                  alu_strobe,
   input  logic                  fl_in,
   input  logic                  fv_in,
   output logic [DATA_WIDTH-1:0] result,
   flag_bus_if.src               flags
);
   import cft_flag_pkg::*;

   localparam int MSB = DATA_WIDTH - 1;

   logic [DATA_WIDTH-1:0] addend;
   logic                  carry_in;
   logic [DATA_WIDTH:0]   sum;
   logic                  overflow;
   logic                  arith_op;
   logic                  link_op;
   logic                  l_next;
   logic                  v_next;

   ////////////////////////////////////////////////////////////
   // Adder
   ////////////////////////////////////////////////////////////

   // SUB is a + ~b + 1, so the link holds carry out, not borrow
   assign addend   = (op == SUB) ? ~b : b;
   assign carry_in = (op == SUB);

   // One extra bit on top catches the carry
   assign sum = {1'b0, a} + {1'b0, addend} + {{DATA_WIDTH{1'b0}}, carry_in};

   // Signed overflow when both adder inputs agree in sign and the sum does not
   assign overflow = (a[MSB] == addend[MSB]) && (sum[MSB] != a[MSB]);

   ////////////////////////////////////////////////////////////
   // Result and next L, V
   ////////////////////////////////////////////////////////////

   always_comb begin
      // Defaults: pass a, hold the current link and overflow
      result = a;
      l_next = fl_in;
      v_next = fv_in;
      case (op)
         ADD, SUB: begin
            result = sum[MSB:0];
            l_next = sum[DATA_WIDTH];
            v_next = overflow;
         end
         AND: result = a & b;
         OR:  result = a | b;
         XOR: result = a ^ b;
         NOT: result = ~a;
         // Link ops keep V as it was
         CPL: l_next = ~fl_in;
         CLL: l_next = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Flag outputs and strobes
   ////////////////////////////////////////////////////////////

   assign arith_op = (op == ADD) || (op == SUB);
   assign link_op  = (op == CPL) || (op == CLL);

   // N and Z follow the result for every operation
   assign flags.fn = result[MSB];
   assign flags.fz = (result == '0);

   assign flags.fl = l_next;
   assign flags.fv = v_next;

   // Every committed op updates N and Z
   assign flags.upd_nz = alu_strobe;
   // L and V only for arithmetic and link ops
   assign flags.upd_lv = alu_strobe & (arith_op | link_op);

endmodule

/* logic/flag_register.sv */
// Flags load on clk4 edges; a bus write (nflagwe low) overrides an ALU commit in the same cycle
module flag_register (
   input  logic       clk4,
   input  logic       rst_n,
   flag_bus_if.sink   alu_in,
   input  logic       nflagwe,
   input  logic [7:0] wdata,
   flag_bus_if.src    flags
);
   import cft_flag_pkg::*;

   // Held flag state
   logic fn_q;
   logic fz_q;
   logic fl_q;
   logic fv_q;
   logic fi_q;

   ////////////////////////////////////////////////////////////
   // Flag state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         fn_q <= 1'b0;
         fz_q <= 1'b0;
         fl_q <= 1'b0;
         fv_q <= 1'b0;
         fi_q <= 1'b0;
      end else begin
         // ALU commit, N and Z
         if (alu_in.upd_nz) begin
            fn_q <= alu_in.fn;
            fz_q <= alu_in.fz;
         end

         // ALU commit, L and V
         if (alu_in.upd_lv) begin
            fl_q <= alu_in.fl;
            fv_q <= alu_in.fv;
         end

         // Bus write comes last so it wins over the ALU
         // N and Z have no bus path
         if (!nflagwe) begin
            fi_q <= wdata[FLAG_BIT_FI];
            fv_q <= wdata[FLAG_BIT_FV];
            fl_q <= wdata[FLAG_BIT_FL];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////

   assign flags.fn = fn_q;
   assign flags.fz = fz_q;
   assign flags.fl = fl_q;
   assign flags.fv = fv_q;
   assign flags.fi = fi_q;

endmodule

/* logic/flag_unit.sv */
// Strobes are combinational from the addresses; outputs read zero when disabled, no tri-state
module flag_unit (
   input  logic [4:0] waddr,
   input  logic [4:0] raddr,
   input  logic       nfpflags,
   flag_bus_if.view   flags,
   output logic [7:0] ibus_flags,
   output logic       nflagoe,
   output logic       nflagwe,
   output logic [7:0] fpd
);
   import cft_flag_pkg::*;

   logic [7:0] wy;
   logic [7:0] ry;
   logic [7:0] flag_byte;

   // '138 style decoder with active-low outputs
   // Enabled only for the 01xxx address block
   function automatic logic [7:0] decode_138(input logic [4:0] addr);
      logic [7:0] y;
      y = 8'hff;
      if (addr[4:3] == ADDR_FLAGS[4:3]) begin
         y[addr[2:0]] = 1'b0;
      end
      return y;
   endfunction

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   assign wy = decode_138(waddr);
   assign ry = decode_138(raddr);

   // Either the MBP alias or the flags proper selects the register
   assign nflagwe = wy[ADDR_MBP_FLAGS[2:0]] & wy[ADDR_FLAGS[2:0]];
   assign nflagoe = ry[ADDR_MBP_FLAGS[2:0]] & ry[ADDR_FLAGS[2:0]];

   ////////////////////////////////////////////////////////////
   // Flag byte
   ////////////////////////////////////////////////////////////

   always_comb begin
      // Reserved and unused bits stay zero
      flag_byte = 8'h00;
      flag_byte[FLAG_BIT_FI] = flags.fi;
      flag_byte[FLAG_BIT_FV] = flags.fv;
      flag_byte[FLAG_BIT_FL] = flags.fl;
      flag_byte[FLAG_BIT_FZ] = flags.fz;
      flag_byte[FLAG_BIT_FN] = flags.fn;
   end

   // Internal bus upper half, only during a flag read
   assign ibus_flags = nflagoe ? 8'h00 : flag_byte;

   // Front panel lights, same layout as the bus byte
   assign fpd = nfpflags ? 8'h00 : flag_byte;

endmodule

/* logic/flag_subsystem.sv */
// Flag section top level; only IBUS[15:8] is used, the low bus byte is not part of flags
module flag_subsystem #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                  clk4,
   input  logic                  rst_n,
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   input  cft_flag_pkg::alu_op_t alu_op,
   input  logic                  alu_strobe,
   input  logic [4:0]            waddr,
   input  logic [4:0]            raddr,
   input  logic [15:0]           ibus_in,
   input  logic                  nfpflags,
   output logic [DATA_WIDTH-1:0] result,
   output logic [7:0]            ibus_flags,
   output logic                  nflagoe,
   output logic                  nflagwe,
   output logic [7:0]            fpd
);

   ////////////////////////////////////////////////////////////
   // Internal flag buses
   ////////////////////////////////////////////////////////////

   // ALU to register: candidate flags and strobes
   flag_bus_if alu_bus ();
   // Register to flag unit: held flags
   flag_bus_if flag_bus ();

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   // Link and overflow feed back for CPL, CLL and logic ops
   alu_flags #(
      .DATA_WIDTH (DATA_WIDTH)
   ) alu_i (
      .a          (a),
      .b          (b),
      .op         (alu_op),
      .alu_strobe (alu_strobe),
      .fl_in      (flag_bus.fl),
      .fv_in      (flag_bus.fv),
      .result     (result),
      .flags      (alu_bus)
   );

   // Write data is the upper bus byte
   flag_register reg_i (
      .clk4    (clk4),
      .rst_n   (rst_n),
      .alu_in  (alu_bus),
      .nflagwe (nflagwe),
      .wdata   (ibus_in[15:8]),
      .flags   (flag_bus)
   );

   flag_unit unit_i (
      .waddr      (waddr),
      .raddr      (raddr),
      .nfpflags   (nfpflags),
      .flags      (flag_bus),
      .ibus_flags (ibus_flags),
      .nflagoe    (nflagoe),
      .nflagwe    (nflagwe),
      .fpd        (fpd)
   );

endmodule

/* sim/flag_subsystem_sva.sv */
// Bound into flag_register; rst_n is synchronous, so checks sample at clk4 rising edges
module flag_subsystem_sva (
   input logic clk4,
   input logic rst_n,
   input logic fn,
   input logic fz,
   input logic fl,
   input logic fv,
   input logic fi,
   input logic upd_nz,
   input logic nflagwe
);

   // Failures so far, read back by the testbench
   int fail_count = 0;

   ////////////////////////////////////////////////////////////
   // Reset and hold rules
   ////////////////////////////////////////////////////////////

   // Every flag clear one edge after reset is sampled
   a_reset_clears: assert property (@(posedge clk4) !rst_n |=> !(fn || fz || fl || fv || fi))
      else begin
         fail_count++;
         $error("Flags not all zero in the cycle after reset");
      end

   // N and Z only move on an ALU commit
   a_nz_hold: assert property (@(posedge clk4) disable iff (!rst_n)
                               !upd_nz |=> $stable(fn) && $stable(fz))
      else begin
         fail_count++;
         $error("N or Z changed without an ALU commit");
      end

   // I has a bus path only
   a_fi_hold: assert property (@(posedge clk4) disable iff (!rst_n)
                               nflagwe |=> $stable(fi))
      else begin
         fail_count++;
         $error("I changed without a flag write strobe");
      end

endmodule

bind flag_register flag_subsystem_sva sva_i (
   .clk4    (clk4),
   .rst_n   (rst_n),
   .fn      (fn_q),
   .fz      (fz_q),
   .fl      (fl_q),
   .fv      (fv_q),
   .fi      (fi_q),
   .upd_nz  (alu_in.upd_nz),
   .nflagwe (nflagwe)
);

/* sim/flag_subsystem_tb.sv */
// Random test at DATA_WIDTH 16 with seed 68; needs flag_subsystem_sva bound into flag_register
module flag_subsystem_tb;
   import cft_flag_pkg::*;

   localparam int DW             = 16;
   localparam int RANDOM_CYCLES  = 2000;
   // Reset, address sweep and directed cases fit inside the margin
   localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 500;

   logic          clk4 = 1'b0;
   logic          rst_n;
   logic [DW-1:0] a;
   logic [DW-1:0] b;
   alu_op_t       alu_op;
   logic          alu_strobe;
   logic [4:0]    waddr;
   logic [4:0]    raddr;
   logic [15:0]   ibus_in;
   logic          nfpflags;
   logic [DW-1:0] result;
   logic [7:0]    ibus_flags;
   logic          nflagoe;
   logic          nflagwe;
   logic [7:0]    fpd;

   // Reference flags, updated at each modeled clock edge
   logic m_fn = 1'b0;
   logic m_fz = 1'b0;
   logic m_fl = 1'b0;
   logic m_fv = 1'b0;
   logic m_fi = 1'b0;

   integer seed = 68;
   int     error_count = 0;
   int     check_count = 0;
   int     cycle_count = 0;

   flag_subsystem #(.DATA_WIDTH(DW)) dut_i (.*);

   always #5 clk4 = ~clk4;

   // Watchdog
   always @(posedge clk4) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   // SUB keeps no-borrow in the carry, so carry is set when a >= b
   task automatic alu_model(input logic [DW-1:0] x, input logic [DW-1:0] y,
                            input alu_op_t op, output logic [DW-1:0] res,
                            output logic carry, output logic ovf);
      logic [DW:0] wide;
      res   = x;
      carry = 1'b0;
      ovf   = 1'b0;
      case (op)
         ADD: begin
            wide  = {1'b0, x} + {1'b0, y};
            res   = wide[DW-1:0];
            carry = wide[DW];
            ovf   = (x[DW-1] == y[DW-1]) && (res[DW-1] != x[DW-1]);
         end
         SUB: begin
            res   = x - y;
            carry = (x >= y);
            ovf   = (x[DW-1] != y[DW-1]) && (res[DW-1] != x[DW-1]);
         end
         AND: res = x & y;
         OR:  res = x | y;
         XOR: res = x ^ y;
         NOT: res = ~x;
         default: res = x;
      endcase
   endtask

   task automatic update_model;
      logic [DW-1:0] res;
      logic          c;
      logic          v;
      alu_model(a, b, alu_op, res, c, v);
      if (!rst_n) begin
         {m_fi, m_fv, m_fl, m_fz, m_fn} = 5'b0;
      end else begin
         if (alu_strobe) begin
            m_fn = res[DW-1];
            m_fz = (res == '0);
            if (alu_op == ADD || alu_op == SUB) begin
               m_fl = c;
               m_fv = v;
            end else if (alu_op == CPL) begin
               m_fl = !m_fl;
            end else if (alu_op == CLL) begin
               m_fl = 1'b0;
            end
         end
         // Bus write lands after the ALU so it takes priority
         if (waddr == 5'd13 || waddr == 5'd14) begin
            m_fi = ibus_in[15];
            m_fv = ibus_in[13];
            m_fl = ibus_in[12];
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      assert (actual === expected) else begin
         error_count++;
         $display("FAILED %s expected %h got %h", name, expected, actual);
      end
   endtask

   task automatic check_outputs;
      logic [DW-1:0] exp_res;
      logic          c;
      logic          v;
      logic [7:0]    exp_byte;
      logic          exp_we;
      logic          exp_oe;
      alu_model(a, b, alu_op, exp_res, c, v);
      // Layout fi, 0, fv, fl, fz, fn, 0, 0
      exp_byte = {m_fi, 1'b0, m_fv, m_fl, m_fz, m_fn, 2'b00};
      exp_we   = !(waddr == 5'd13 || waddr == 5'd14);
      exp_oe   = !(raddr == 5'd13 || raddr == 5'd14);
      check_value("result", exp_res, result);
      check_value("nflagwe", exp_we, nflagwe);
      check_value("nflagoe", exp_oe, nflagoe);
      check_value("ibus_flags", exp_oe ? 8'h00 : exp_byte, ibus_flags);
      check_value("fpd", nfpflags ? 8'h00 : exp_byte, fpd);
   endtask

   // Called just after a rising edge; drives, checks at the falling edge, models the edge
   task automatic apply_cycle(input logic [DW-1:0] a_v, input logic [DW-1:0] b_v,
                              input alu_op_t op_v, input logic strobe_v,
                              input logic [4:0] wa, input logic [4:0] ra,
                              input logic [15:0] bus_v, input logic nfp_v);
      a          = a_v;
      b          = b_v;
      alu_op     = op_v;
      alu_strobe = strobe_v;
      waddr      = wa;
      raddr      = ra;
      ibus_in    = bus_v;
      nfpflags   = nfp_v;
      @(negedge clk4);
      check_outputs();
      update_model();
      @(posedge clk4);
      #1;
   endtask

   ////////////////////////////////////////////////////////////
   // Random stimulus helpers
   ////////////////////////////////////////////////////////////

   // Corner operands often enough to hit zero, carry and overflow
   function automatic logic [DW-1:0] pick_operand();
      logic [2:0] r;
      r = $random(seed);
      case (r)
         3'd0: return '0;
         3'd1: return '1;
         3'd2: return {1'b1, {(DW-1){1'b0}}};
         3'd3: return {1'b0, {(DW-1){1'b1}}};
         default: return $random(seed);
      endcase
   endfunction

   // Half the picks land on the flag addresses
   function automatic logic [4:0] pick_address();
      logic [1:0] r;
      r = $random(seed);
      case (r)
         2'd0: return 5'd13;
         2'd1: return 5'd14;
         default: return $random(seed);
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Test flow
   ////////////////////////////////////////////////////////////

   initial begin
      logic [2:0] op_bits;
      int         fails_sva;
      rst_n      = 1'b0;
      a          = '0;
      b          = '0;
      alu_op     = ADD;
      alu_strobe = 1'b0;
      waddr      = 5'd0;
      raddr      = 5'd0;
      ibus_in    = 16'h0000;
      nfpflags   = 1'b1;
      repeat (2) @(posedge clk4);
      #1;
      rst_n = 1'b1;

      // Flags read zero on the panel right after reset
      apply_cycle('0, '0, ADD, 1'b0, 5'd0, 5'd14, 16'h0000, 1'b0);

      // Decode sweep over every address
      for (int i = 0; i < 32; i++) begin
         apply_cycle('0, '0, ADD, 1'b0, i[4:0], i[4:0], 16'h0000, 1'b0);
      end

      // Bus write of all ones, then overflow from 7fff + 1
      apply_cycle('0, '0, ADD, 1'b0, 5'd14, 5'd13, 16'hff00, 1'b0);
      apply_cycle(16'h7fff, 16'h0001, ADD, 1'b1, 5'd0, 5'd14, 16'h0000, 1'b0);
      // Link ops keep V
      apply_cycle(16'h1234, '0, CPL, 1'b1, 5'd0, 5'd14, 16'h0000, 1'b0);
      apply_cycle(16'h1234, '0, CPL, 1'b1, 5'd0, 5'd14, 16'h0000, 1'b0);
      apply_cycle(16'h8000, '0, CLL, 1'b1, 5'd0, 5'd14, 16'h0000, 1'b0);
      // ALU commit and bus write in one cycle
      apply_cycle(16'hffff, 16'h0001, ADD, 1'b1, 5'd13, 5'd14, 16'hb000, 1'b0);
      apply_cycle(16'hf0f0, 16'h0f0f, AND, 1'b1, 5'd0, 5'd14, 16'h0000, 1'b0);
      apply_cycle(16'h0005, 16'h0007, SUB, 1'b1, 5'd0, 5'd13, 16'h0000, 1'b0);

      // Reset in the middle of the run
      rst_n = 1'b0;
      apply_cycle('0, '0, ADD, 1'b0, 5'd0, 5'd14, 16'h0000, 1'b0);
      apply_cycle('0, '0, ADD, 1'b0, 5'd0, 5'd14, 16'h0000, 1'b0);
      rst_n = 1'b1;
      apply_cycle('0, '0, ADD, 1'b0, 5'd0, 5'd14, 16'h0000, 1'b0);

      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         op_bits = $random(seed);
         apply_cycle(pick_operand(), pick_operand(), alu_op_t'(op_bits), $random(seed),
                     pick_address(), pick_address(), $random(seed), $random(seed));
      end

      fails_sva = dut_i.reg_i.sva_i.fail_count;
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               check_count, error_count, fails_sva);
      if (error_count == 0 && fails_sva == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* flag_subsystem.f */
logic/cft_flag_pkg.sv
logic/flag_bus_if.sv
logic/alu_flags.sv
logic/flag_register.sv
logic/flag_unit.sv
logic/flag_subsystem.sv
sim/flag_subsystem_sva.sv
sim/flag_subsystem_tb.sv
